/* compile.f */
source/fprint_cfg_pkg.sv
source/fprint_ctrl_pkg.sv
source/comp_registers.sv
source/fprint_ram.sv
source/fprint_csr.sv
source/fprint_unit.sv
source/fprint_comparator.sv
source/fprint_checker_top.sv
testbench/fprint_checker_sva.sv
testbench/fprint_checker_tb.sv

/* Bender.yml */
package:
  name: fprint_checker

sources:
  - files:
      - source/fprint_cfg_pkg.sv
      - source/fprint_ctrl_pkg.sv
      - source/comp_registers.sv
      - source/fprint_ram.sv
      - source/fprint_csr.sv
      - source/fprint_unit.sv
      - source/fprint_comparator.sv
      - source/fprint_checker_top.sv
  - target: test
    files:
      - testbench/fprint_checker_sva.sv
      - testbench/fprint_checker_tb.sv

/* testbench/fprint_checker_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_checker_tb;
	import fprint_cfg_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int REGION_LEN = 4;

	logic clk = 1'b0;
	logic reset;
	logic csr_write;
	logic csr_select_end;
	core_id_t csr_core_in;
	task_id_t csr_task_in;
	ram_addr_t csr_data_in;
	logic csr_done;
	logic fp_valid;
	core_id_t fp_core_in;
	task_id_t fp_task_in;
	fprint_t fp_data;
	logic fp_done;
	logic check_valid;
	logic check_reset;
	task_id_t check_task;
	logic check_done;
	logic result_valid;
	logic result_match;
	core_id_t result_fault_core;
	logic result_fatal;

	// Expectations read by the bound assertions
	logic started;
	logic check_open;
	logic exp_match;
	logic exp_fatal;
	core_id_t exp_fault_core;
	int assert_errors;
	int timeout_errors;
	integer seed = 32'h456b_1715;

	// Model of the regions and the buffer contents
	ram_addr_t m_start [NUM_CORES][NUM_TASKS];
	ram_addr_t m_end [NUM_CORES][NUM_TASKS];
	ram_addr_t m_head [NUM_CORES][NUM_TASKS];
	ram_addr_t m_tail [NUM_CORES][NUM_TASKS];
	fprint_t m_mem [NUM_CORES][RAM_DEPTH];

	fprint_checker_top dut (.*);

	bind fprint_checker_top fprint_checker_sva sva (.*);

	always #2 clk = ~clk;

	function automatic ram_addr_t next_slot(input int core, input task_id_t tsk, input ram_addr_t p);
		if (p == m_end[core][tsk])
			return m_start[core][tsk];
		return p + 1'b1;
	endfunction

	task automatic host_write(input int core, input task_id_t tsk, input ram_addr_t data,
			input logic sel_end);
		int n;
		@(posedge clk);
		started <= 1'b1;
		csr_write <= 1'b1;
		csr_select_end <= sel_end;
		csr_core_in <= core_id_t'(core);
		csr_task_in <= tsk;
		csr_data_in <= data;
		@(posedge clk);
		csr_write <= 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (csr_done)
				break;
		end
		if (n == TIMEOUT) begin
			$display("Timeout: host pointer write for task %0d never finished", tsk);
			timeout_errors++;
		end
	endtask

	// Four-entry regions that do not overlap between tasks
	task automatic configure_region(input task_id_t tsk);
		int k;
		ram_addr_t first;
		for (k = 0; k < NUM_CORES; k++) begin
			first = ram_addr_t'(tsk * 32 + k * 8);
			m_start[k][tsk] = first;
			m_head[k][tsk] = first;
			m_tail[k][tsk] = first;
			m_end[k][tsk] = first + ram_addr_t'(REGION_LEN - 1);
			host_write(k, tsk, first, 1'b0);
			host_write(k, tsk, m_end[k][tsk], 1'b1);
		end
	endtask

	task automatic push_fingerprint(input int core, input task_id_t tsk, input fprint_t data);
		int n;
		m_mem[core][m_head[core][tsk]] = data;
		m_head[core][tsk] = next_slot(core, tsk, m_head[core][tsk]);
		@(posedge clk);
		started <= 1'b1;
		fp_valid <= 1'b1;
		fp_core_in <= core_id_t'(core);
		fp_task_in <= tsk;
		fp_data <= data;
		@(posedge clk);
		fp_valid <= 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (fp_done)
				break;
		end
		if (n == TIMEOUT) begin
			$display("Timeout: fingerprint for core %0d task %0d never stored", core, tsk);
			timeout_errors++;
		end
	endtask

	// bad names the odd core
	// With bad at 3 all three differ and at -1 all agree
	task automatic push_entry(input task_id_t tsk, input int bad);
		fprint_t word;
		int k;
		word = $random(seed);
		for (k = 0; k < NUM_CORES; k++) begin
			if (bad == k || bad == 3)
				push_fingerprint(k, tsk, word ^ (32'h0101_0000 << k));
			else
				push_fingerprint(k, tsk, word);
		end
	endtask

	task automatic run_check(input task_id_t tsk);
		fprint_t a;
		fprint_t b;
		fprint_t c;
		core_id_t odd;
		int k;
		int n;
		a = m_mem[0][m_tail[0][tsk]];
		b = m_mem[1][m_tail[1][tsk]];
		c = m_mem[2][m_tail[2][tsk]];
		for (k = 0; k < NUM_CORES; k++)
			m_tail[k][tsk] = next_slot(k, tsk, m_tail[k][tsk]);
		// The core whose word stands alone against an agreeing pair
		odd = 2'd0;
		if (a == b && b != c)
			odd = 2'd2;
		else if (a == c && a != b)
			odd = 2'd1;
		@(posedge clk);
		started <= 1'b1;
		check_open <= 1'b1;
		exp_match <= (a == b) && (b == c);
		exp_fatal <= (a != b) && (a != c) && (b != c);
		exp_fault_core <= odd;
		check_valid <= 1'b1;
		check_task <= tsk;
		@(posedge clk);
		check_valid <= 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (check_done)
				break;
		end
		if (n == TIMEOUT) begin
			$display("Timeout: check of task %0d never finished", tsk);
			timeout_errors++;
		end
		check_open <= 1'b0;
	endtask

	task automatic restart_task(input task_id_t tsk);
		int k;
		int n;
		for (k = 0; k < NUM_CORES; k++) begin
			m_head[k][tsk] = m_start[k][tsk];
			m_tail[k][tsk] = m_start[k][tsk];
		end
		@(posedge clk);
		started <= 1'b1;
		check_reset <= 1'b1;
		check_task <= tsk;
		@(posedge clk);
		check_reset <= 1'b0;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clk);
			if (check_done)
				break;
		end
		if (n == TIMEOUT) begin
			$display("Timeout: reset of task %0d never acknowledged", tsk);
			timeout_errors++;
		end
	endtask

	initial begin
		reset = 1'b1;
		csr_write = 1'b0;
		csr_select_end = 1'b0;
		csr_core_in = '0;
		csr_task_in = '0;
		csr_data_in = '0;
		fp_valid = 1'b0;
		fp_core_in = '0;
		fp_task_in = '0;
		fp_data = '0;
		check_valid = 1'b0;
		check_reset = 1'b0;
		check_task = '0;
		started = 1'b0;
		check_open = 1'b0;
		exp_match = 1'b0;
		exp_fatal = 1'b0;
		exp_fault_core = '0;
		assert_errors = 0;
		timeout_errors = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		// Quiet outputs before any command
		repeat (6) @(posedge clk);
		configure_region(1);
		configure_region(2);
		configure_region(3);
		configure_region(4);
		// Six entries through a four-entry region so head and tail wrap
		push_entry(1, -1);
		run_check(1);
		push_entry(1, 0);
		run_check(1);
		push_entry(1, 1);
		run_check(1);
		push_entry(1, 2);
		run_check(1);
		push_entry(1, 3);
		run_check(1);
		push_entry(1, -1);
		run_check(1);
		// The fifth entry sits at the start pointer only after a wrap
		restart_task(1);
		run_check(1);
		// Task 2 waits while task 3 is reset
		push_entry(2, -1);
		push_entry(2, 2);
		push_entry(3, -1);
		push_entry(3, -1);
		run_check(3);
		restart_task(3);
		push_entry(3, 3);
		run_check(3);
		run_check(2);
		// Host, producer and comparator all at once
		fork
			configure_region(5);
			begin
				push_entry(4, 1);
				push_entry(4, 3);
			end
			run_check(2);
		join
		run_check(4);
		run_check(4);
		push_entry(5, 0);
		run_check(5);
		repeat (4) @(posedge clk);
		$display("Closing: %0d assertion errors, %0d timeouts", assert_errors, timeout_errors);
		if (assert_errors == 0 && timeout_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/fprint_checker_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_checker_sva (
	input logic                     clk,
	input logic                     reset,
	input logic                     csr_done,
	input logic                     fp_done,
	input logic                     check_done,
	input logic                     result_valid,
	input logic                     result_match,
	input fprint_cfg_pkg::core_id_t result_fault_core,
	input logic                     result_fatal
);

	// Nothing completes before the first command
	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!fprint_checker_tb.started |-> !(csr_done || fp_done || result_valid || check_done))
	else begin
		$error("[FAIL] %0t done or result pulse before any command", $time);
		fprint_checker_tb.assert_errors++;
	end

	// A result only while a check is outstanding
	result_expected: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> fprint_checker_tb.check_open)
	else begin
		$error("[FAIL] %0t result_valid without an outstanding check", $time);
		fprint_checker_tb.assert_errors++;
	end

	match_follows_model: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> result_match == fprint_checker_tb.exp_match)
	else begin
		$error("[FAIL] %0t result_match %b, model %b", $time, result_match,
			fprint_checker_tb.exp_match);
		fprint_checker_tb.assert_errors++;
	end

	fatal_follows_model: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> result_fatal == fprint_checker_tb.exp_fatal)
	else begin
		$error("[FAIL] %0t result_fatal %b, model %b", $time, result_fatal,
			fprint_checker_tb.exp_fatal);
		fprint_checker_tb.assert_errors++;
	end

	// Odd core out, zero when all agree
	fault_core_follows_model: assert property (@(posedge clk) disable iff (reset)
		result_valid && !fprint_checker_tb.exp_fatal
		|-> result_fault_core == fprint_checker_tb.exp_fault_core)
	else begin
		$error("[FAIL] %0t result_fault_core %0d, model %0d", $time, result_fault_core,
			fprint_checker_tb.exp_fault_core);
		fprint_checker_tb.assert_errors++;
	end

endmodule

`default_nettype wire

/* source/fprint_checker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_checker_top (
	input  logic                      clk,
	input  logic                      reset,
	// Host configuration
	input  logic                      csr_write,
	input  logic                      csr_select_end,
	input  fprint_cfg_pkg::core_id_t  csr_core_in,
	input  fprint_cfg_pkg::task_id_t  csr_task_in,
	input  fprint_cfg_pkg::ram_addr_t csr_data_in,
	output logic                      csr_done,
	// Fingerprints from the cores
	input  logic                      fp_valid,
	input  fprint_cfg_pkg::core_id_t  fp_core_in,
	input  fprint_cfg_pkg::task_id_t  fp_task_in,
	input  fprint_cfg_pkg::fprint_t   fp_data,
	output logic                      fp_done,
	// Checks and results
	input  logic                      check_valid,
	input  logic                      check_reset,
	input  fprint_cfg_pkg::task_id_t  check_task,
	output logic                      check_done,
	output logic                      result_valid,
	output logic                      result_match,
	output fprint_cfg_pkg::core_id_t  result_fault_core,
	output logic                      result_fatal
);
	import fprint_cfg_pkg::*;

	// Host to pointer store
	logic pointer_start_write;
	logic pointer_end_write;
	logic pointer_ack;
	core_id_t csr_core;
	task_id_t csr_task;
	ram_addr_t csr_data;

	// Producer to pointer store and buffer
	logic inc_head;
	logic inc_head_ack;
	core_id_t fp_core;
	task_id_t fp_task;
	ram_addr_t head_pointer;
	logic write_enable;
	core_id_t write_core;
	ram_addr_t write_addr;
	fprint_t write_data;

	// Comparator to pointer store and buffer
	logic inc_tail;
	logic inc_tail_ack;
	logic reset_task;
	logic reset_task_ack;
	task_id_t cmp_task;
	ram_addr_t tail_pointer_0;
	ram_addr_t tail_pointer_1;
	ram_addr_t tail_pointer_2;
	ram_addr_t read_addr_0;
	ram_addr_t read_addr_1;
	ram_addr_t read_addr_2;
	fprint_t read_data_0;
	fprint_t read_data_1;
	fprint_t read_data_2;

	// Port names match the nets above one to one
	fprint_csr u_csr (.*);

	comp_registers u_pointers (.*);

	fprint_unit u_unit (.*);

	fprint_ram u_ram (.*);

	fprint_comparator u_comparator (.*);

endmodule

`default_nettype wire

/* source/fprint_comparator.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_comparator (
	input  logic                      clk,
	input  logic                      reset,
	// Check commands
	input  logic                      check_valid,
	input  logic                      check_reset,
	input  fprint_cfg_pkg::task_id_t  check_task,
	output logic                      check_done,
	// Pointer store
	input  fprint_cfg_pkg::ram_addr_t tail_pointer_0,
	input  fprint_cfg_pkg::ram_addr_t tail_pointer_1,
	input  fprint_cfg_pkg::ram_addr_t tail_pointer_2,
	input  logic                      inc_tail_ack,
	input  logic                      reset_task_ack,
	output fprint_cfg_pkg::task_id_t  cmp_task,
	output logic                      inc_tail,
	output logic                      reset_task,
	// Buffer read ports
	input  fprint_cfg_pkg::fprint_t   read_data_0,
	input  fprint_cfg_pkg::fprint_t   read_data_1,
	input  fprint_cfg_pkg::fprint_t   read_data_2,
	output fprint_cfg_pkg::ram_addr_t read_addr_0,
	output fprint_cfg_pkg::ram_addr_t read_addr_1,
	output fprint_cfg_pkg::ram_addr_t read_addr_2,
	// Vote result
	output logic                      result_valid,
	output logic                      result_match,
	output fprint_cfg_pkg::core_id_t  result_fault_core,
	output logic                      result_fatal
);
	import fprint_cfg_pkg::*;
	import fprint_ctrl_pkg::*;

	cmp_state_t state;
	// High in the second read cycle while the buffer read is under way
	logic read_phase;
	logic eq_01;
	logic eq_02;
	logic eq_12;
	core_id_t vote_fault_core;

	assign eq_01 = (read_data_0 == read_data_1);
	assign eq_02 = (read_data_0 == read_data_2);
	assign eq_12 = (read_data_1 == read_data_2);

	// Core left alone by an agreeing pair
	always_comb begin
		vote_fault_core = core_id_t'(0);
		if (eq_01 && !eq_02)
			vote_fault_core = core_id_t'(2);
		else if (eq_02 && !eq_01)
			vote_fault_core = core_id_t'(1);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= cmp_idle;
			read_phase <= 1'b0;
			result_valid <= 1'b0;
			result_match <= 1'b0;
			result_fault_core <= '0;
			result_fatal <= 1'b0;
		end else begin
			result_valid <= 1'b0;
			case (state)
				cmp_idle: begin
					read_phase <= 1'b0;
					if (check_valid)
						state <= cmp_read;
					else if (check_reset)
						state <= cmp_reset_req;
				end
				cmp_read: begin
					read_phase <= !read_phase;
					if (read_phase)
						state <= cmp_vote;
				end
				cmp_vote: begin
					result_valid <= 1'b1;
					result_match <= eq_01 && eq_12;
					result_fault_core <= vote_fault_core;
					result_fatal <= !eq_01 && !eq_02 && !eq_12;
					state <= cmp_tail_req;
				end
				cmp_tail_req: begin
					if (inc_tail_ack)
						state <= cmp_done;
				end
				cmp_reset_req: begin
					if (reset_task_ack)
						state <= cmp_done;
				end
				default: state <= cmp_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cmp_idle && (check_valid || check_reset))
			cmp_task <= check_task;
	end

	assign inc_tail = (state == cmp_tail_req);
	assign reset_task = (state == cmp_reset_req);
	assign check_done = (state == cmp_done);

	// Oldest unchecked entry of each core
	assign read_addr_0 = tail_pointer_0;
	assign read_addr_1 = tail_pointer_1;
	assign read_addr_2 = tail_pointer_2;

endmodule

`default_nettype wire

/* source/fprint_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_unit (
	input  logic                      clk,
	input  logic                      reset,
	// Finished fingerprint from a core
	input  logic                      fp_valid,
	input  fprint_cfg_pkg::core_id_t  fp_core_in,
	input  fprint_cfg_pkg::task_id_t  fp_task_in,
	input  fprint_cfg_pkg::fprint_t   fp_data,
	output logic                      fp_done,
	// Head pointer access
	input  fprint_cfg_pkg::ram_addr_t head_pointer,
	input  logic                      inc_head_ack,
	output fprint_cfg_pkg::core_id_t  fp_core,
	output fprint_cfg_pkg::task_id_t  fp_task,
	output logic                      inc_head,
	// Buffer write port
	output logic                      write_enable,
	output fprint_cfg_pkg::core_id_t  write_core,
	output fprint_cfg_pkg::ram_addr_t write_addr,
	output fprint_cfg_pkg::fprint_t   write_data
);
	import fprint_cfg_pkg::*;

	logic busy;
	// Head read in flight for the latched core and task
	logic lookup;
	logic written;
	fprint_t data_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			lookup <= 1'b0;
			written <= 1'b0;
			fp_done <= 1'b0;
		end else begin
			fp_done <= inc_head && inc_head_ack;
			lookup <= fp_valid && !busy;
			if (fp_valid && !busy)
				busy <= 1'b1;
			else if (inc_head && inc_head_ack)
				busy <= 1'b0;
			if (write_enable)
				written <= 1'b1;
			else if (inc_head && inc_head_ack)
				written <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fp_valid && !busy) begin
			fp_core <= fp_core_in;
			fp_task <= fp_task_in;
			data_q <= fp_data;
		end
	end

	// Store at the current head, then ask for the head advance
	assign write_enable = busy && !lookup && !written;
	assign inc_head = busy && !lookup;
	assign write_core = fp_core;
	assign write_addr = head_pointer;
	assign write_data = data_q;

endmodule

`default_nettype wire

/* source/fprint_csr.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_csr (
	input  logic                      clk,
	input  logic                      reset,
	// Host strobe and command
	input  logic                      csr_write,
	input  logic                      csr_select_end,
	input  fprint_cfg_pkg::core_id_t  csr_core_in,
	input  fprint_cfg_pkg::task_id_t  csr_task_in,
	input  fprint_cfg_pkg::ram_addr_t csr_data_in,
	output logic                      csr_done,
	// Toward the pointer store
	input  logic                      pointer_ack,
	output logic                      pointer_start_write,
	output logic                      pointer_end_write,
	output fprint_cfg_pkg::core_id_t  csr_core,
	output fprint_cfg_pkg::task_id_t  csr_task,
	output fprint_cfg_pkg::ram_addr_t csr_data
);
	logic pending;
	logic select_end;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending <= 1'b0;
			csr_done <= 1'b0;
		end else begin
			csr_done <= pending && pointer_ack;
			if (csr_write && !pending)
				pending <= 1'b1;
			else if (pointer_ack)
				pending <= 1'b0;
		end
	end

	// Command held stable while the request is up
	always_ff @(posedge clk) begin
		if (csr_write && !pending) begin
			select_end <= csr_select_end;
			csr_core <= csr_core_in;
			csr_task <= csr_task_in;
			csr_data <= csr_data_in;
		end
	end

	assign pointer_start_write = pending && !select_end;
	assign pointer_end_write = pending && select_end;

endmodule

`default_nettype wire

/* source/fprint_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module fprint_ram (
	input  logic                      clk,
	input  logic                      write_enable,
	input  fprint_cfg_pkg::core_id_t  write_core,
	input  fprint_cfg_pkg::ram_addr_t write_addr,
	input  fprint_cfg_pkg::fprint_t   write_data,
	input  fprint_cfg_pkg::ram_addr_t read_addr_0,
	input  fprint_cfg_pkg::ram_addr_t read_addr_1,
	input  fprint_cfg_pkg::ram_addr_t read_addr_2,
	output fprint_cfg_pkg::fprint_t   read_data_0,
	output fprint_cfg_pkg::fprint_t   read_data_1,
	output fprint_cfg_pkg::fprint_t   read_data_2
);
	import fprint_cfg_pkg::*;

	// One bank per core
	fprint_t mem [NUM_CORES][RAM_DEPTH];
	ram_addr_t rd_addr [NUM_CORES];
	fprint_t rd_q [NUM_CORES];

	assign rd_addr[0] = read_addr_0;
	assign rd_addr[1] = read_addr_1;
	assign rd_addr[2] = read_addr_2;

	always_ff @(posedge clk) begin
		if (write_enable)
			mem[write_core][write_addr] <= write_data;
		for (int b = 0; b < NUM_CORES; b++)
			rd_q[b] <= mem[b][rd_addr[b]];
	end

	assign read_data_0 = rd_q[0];
	assign read_data_1 = rd_q[1];
	assign read_data_2 = rd_q[2];

endmodule

`default_nettype wire

/* source/comp_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module comp_registers (
	input  logic                      clk,
	input  logic                      reset,
	// Host configuration side
	input  logic                      pointer_start_write,
	input  logic                      pointer_end_write,
	input  fprint_cfg_pkg::core_id_t  csr_core,
	input  fprint_cfg_pkg::task_id_t  csr_task,
	input  fprint_cfg_pkg::ram_addr_t csr_data,
	output logic                      pointer_ack,
	// Fingerprint producer side
	input  logic                      inc_head,
	input  fprint_cfg_pkg::core_id_t  fp_core,
	input  fprint_cfg_pkg::task_id_t  fp_task,
	output fprint_cfg_pkg::ram_addr_t head_pointer,
	output logic                      inc_head_ack,
	// Comparator side
	input  logic                      inc_tail,
	input  logic                      reset_task,
	input  fprint_cfg_pkg::task_id_t  cmp_task,
	output fprint_cfg_pkg::ram_addr_t tail_pointer_0,
	output fprint_cfg_pkg::ram_addr_t tail_pointer_1,
	output fprint_cfg_pkg::ram_addr_t tail_pointer_2,
	output logic                      inc_tail_ack,
	output logic                      reset_task_ack
);
	import fprint_cfg_pkg::*;
	import fprint_ctrl_pkg::*;

	ram_addr_t start_mem [NUM_CORES][NUM_TASKS];
	ram_addr_t end_mem [NUM_CORES][NUM_TASKS];
	ram_addr_t head_mem [NUM_CORES][NUM_TASKS];
	ram_addr_t tail_mem [NUM_CORES][NUM_TASKS];

	// Region bounds for the producer's core and task
	ram_addr_t start_fp_q;
	ram_addr_t end_fp_q;

	// Region bounds and tails of the comparator's task, per core
	ram_addr_t start_cmp_q [NUM_CORES];
	ram_addr_t end_cmp_q [NUM_CORES];
	ram_addr_t tail_q [NUM_CORES];

	ptr_state_t state;

	// Circular step, back to start once the end entry was used
	function automatic ram_addr_t wrap_inc(ram_addr_t cur, ram_addr_t last, ram_addr_t first);
		return (cur == last) ? first : cur + 1'b1;
	endfunction

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ptr_idle;
		end else begin
			case (state)
				ptr_idle: begin
					if (pointer_start_write)
						state <= ptr_start_write;
					else if (pointer_end_write)
						state <= ptr_end_write;
					else if (inc_head)
						state <= ptr_head_inc;
					else if (inc_tail)
						state <= ptr_tail_inc;
					else if (reset_task)
						state <= ptr_task_reset;
				end
				ptr_start_write: state <= ptr_ack;
				ptr_end_write:   state <= ptr_ack;
				ptr_head_inc:    state <= ptr_head_ack;
				ptr_tail_inc:    state <= ptr_tail_ack;
				ptr_task_reset:  state <= ptr_reset_ack;
				default:         state <= ptr_idle;
			endcase
		end
	end

	assign pointer_ack = (state == ptr_ack);
	assign inc_head_ack = (state == ptr_head_ack);
	assign inc_tail_ack = (state == ptr_tail_ack);
	assign reset_task_ack = (state == ptr_reset_ack);

	// Only one operation state is active at a time
	always_ff @(posedge clk) begin
		case (state)
			ptr_start_write: begin
				start_mem[csr_core][csr_task] <= csr_data;
				head_mem[csr_core][csr_task] <= csr_data;
				tail_mem[csr_core][csr_task] <= csr_data;
			end
			ptr_end_write: begin
				end_mem[csr_core][csr_task] <= csr_data;
			end
			ptr_head_inc: begin
				head_mem[fp_core][fp_task] <= wrap_inc(head_pointer, end_fp_q, start_fp_q);
			end
			ptr_tail_inc: begin
				for (int c = 0; c < NUM_CORES; c++)
					tail_mem[c][cmp_task] <= wrap_inc(tail_q[c], end_cmp_q[c], start_cmp_q[c]);
			end
			ptr_task_reset: begin
				for (int c = 0; c < NUM_CORES; c++) begin
					head_mem[c][cmp_task] <= start_cmp_q[c];
					tail_mem[c][cmp_task] <= start_cmp_q[c];
				end
			end
			default: begin
			end
		endcase
	end

	// Read ports, one cycle behind the requester's task numbers
	always_ff @(posedge clk) begin
		head_pointer <= head_mem[fp_core][fp_task];
		start_fp_q <= start_mem[fp_core][fp_task];
		end_fp_q <= end_mem[fp_core][fp_task];
		for (int c = 0; c < NUM_CORES; c++) begin
			tail_q[c] <= tail_mem[c][cmp_task];
			start_cmp_q[c] <= start_mem[c][cmp_task];
			end_cmp_q[c] <= end_mem[c][cmp_task];
		end
	end

	assign tail_pointer_0 = tail_q[0];
	assign tail_pointer_1 = tail_q[1];
	assign tail_pointer_2 = tail_q[2];

endmodule

`default_nettype wire

/* source/fprint_ctrl_pkg.sv */
`default_nettype none

package fprint_ctrl_pkg;

	// Pointer store, every operation followed by its ack state
	typedef enum logic [3:0] {
		ptr_idle,
		ptr_start_write,
		ptr_end_write,
		ptr_ack,
		ptr_head_inc,
		ptr_head_ack,
		ptr_tail_inc,
		ptr_tail_ack,
		ptr_task_reset,
		ptr_reset_ack
	} ptr_state_t;

	// Comparator check sequence
	typedef enum logic [2:0] {
		cmp_idle,
		cmp_read,
		cmp_vote,
		cmp_tail_req,
		cmp_reset_req,
		cmp_done
	} cmp_state_t;

endpackage

`default_nettype wire

/* source/fprint_cfg_pkg.sv */
`default_nettype none

package fprint_cfg_pkg;

	// Three logical cores run the same task
	localparam int NUM_CORES = 3;

	// Tasks per core, each with its own region
	localparam int NUM_TASKS = 16;

	// Fingerprint buffer of each core
	localparam int RAM_ADDR_WIDTH = 9;
	localparam int RAM_DEPTH = 1 << RAM_ADDR_WIDTH;

	// CRC signature width
	localparam int FPRINT_WIDTH = 32;

	typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;
	typedef logic [$clog2(NUM_TASKS)-1:0] task_id_t;
	typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
	typedef logic [FPRINT_WIDTH-1:0] fprint_t;

endpackage

`default_nettype wire
